// ==== design/soc_pkg.sv ====
/*
 * Shared definitions for the peripheral subsystem
 * Bus geometry, slave address map, I/O widths and register offsets
 */
package soc_pkg;

	// ------------------------------------------------------------------------
	// Bus geometry
	// ------------------------------------------------------------------------
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W  = 4;

	// Region field sits in the upper address bits
	localparam int REGION_LSB = 17;
	localparam int REGION_W   = ADDR_W - REGION_LSB;

	// Region codes, same map as the full SoC
	localparam logic [REGION_W-1:0] REGION_BRAM  = 15'h0000;
	localparam logic [REGION_W-1:0] REGION_TIMER = 15'h7001;
	localparam logic [REGION_W-1:0] REGION_GPIO  = 15'h7002;

	// 4096 words of block RAM
	localparam int BRAM_ADDR_W = 12;

	// ------------------------------------------------------------------------
	// Board I/O and interrupts
	// ------------------------------------------------------------------------
	localparam int IRQ_W        = 3;
	localparam int BTN_W        = 4;
	localparam int LED_W        = 8;
	localparam int GPIO_BTN_LSB = 8;
	localparam int TIMER_CH     = 2;

	// Decode targets
	typedef enum logic [1:0] {BRAM, TIMER, GPIO, NONE} slave_e;

	// Timer register offsets, word-address bits 3:2
	typedef enum logic [1:0] {CTRL = 2'd0, COMPARE = 2'd1, COUNTER = 2'd2} timer_reg_e;

	// Timer CTRL bit positions
	localparam int CTRL_EN     = 0;
	localparam int CTRL_AR     = 1;
	localparam int CTRL_IRQ_EN = 2;
	localparam int CTRL_TRIG   = 3;

	// GPIO register offsets, word-address bits 3:2
	typedef enum logic [1:0] {IN = 2'd0, OUT = 2'd1, MASK = 2'd2} gpio_reg_e;

endpackage

// ==== design/soc_top.sv ====
/*
 * Peripheral subsystem top level
 * Wishbone master port, decoder, block RAM, timer, GPIO, interrupt vector
 */
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic [ADDR_W-1:0] wb_adr_i,
	input  logic [DATA_W-1:0] wb_dat_i,
	input  logic [SEL_W-1:0]  wb_sel_i,
	input  logic              wb_we_i,
	input  logic              wb_cyc_i,
	input  logic              wb_stb_i,
	input  logic [BTN_W-1:0]  btn_i,
	output logic [DATA_W-1:0] wb_dat_o,
	output logic              wb_ack_o,
	output logic [LED_W-1:0]  led_o,
	output logic [IRQ_W-1:0]  irq_o
);

	// Per-slave strobes and responses
	logic                bram_stb, timer_stb, gpio_stb;
	logic                bram_ack, timer_ack, gpio_ack;
	logic [DATA_W-1:0]   bram_dat, timer_dat, gpio_dat;

	logic [TIMER_CH-1:0] timer_irq;
	logic                gpio_irq;
	logic [DATA_W-1:0]   gpio_in;
	logic [DATA_W-1:0]   gpio_out;

	// ------------------------------------------------------------------------
	// Interconnect
	// ------------------------------------------------------------------------
	wb_decoder u_decoder (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.adr_i       (wb_adr_i),
		.cyc_i       (wb_cyc_i),
		.stb_i       (wb_stb_i),
		.bram_dat_i  (bram_dat),
		.timer_dat_i (timer_dat),
		.gpio_dat_i  (gpio_dat),
		.bram_ack_i  (bram_ack),
		.timer_ack_i (timer_ack),
		.gpio_ack_i  (gpio_ack),
		.bram_stb_o  (bram_stb),
		.timer_stb_o (timer_stb),
		.gpio_stb_o  (gpio_stb),
		.dat_o       (wb_dat_o),
		.ack_o       (wb_ack_o)
	);

	// ------------------------------------------------------------------------
	// Slaves, word addressed from bit 2
	// ------------------------------------------------------------------------
	wb_bram u_bram (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.stb_i   (bram_stb),
		.we_i    (wb_we_i),
		.adr_i   (wb_adr_i[BRAM_ADDR_W+1:2]),
		.dat_i   (wb_dat_i),
		.sel_i   (wb_sel_i),
		.dat_o   (bram_dat),
		.ack_o   (bram_ack)
	);

	// Channel on bit 4, register on bits 3:2
	wb_timer u_timer (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.stb_i   (timer_stb),
		.we_i    (wb_we_i),
		.adr_i   (wb_adr_i[4:2]),
		.dat_i   (wb_dat_i),
		.dat_o   (timer_dat),
		.ack_o   (timer_ack),
		.irq_o   (timer_irq)
	);

	wb_gpio u_gpio (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.stb_i      (gpio_stb),
		.we_i       (wb_we_i),
		.adr_i      (wb_adr_i[3:2]),
		.dat_i      (wb_dat_i),
		.gpio_in_i  (gpio_in),
		.dat_o      (gpio_dat),
		.ack_o      (gpio_ack),
		.gpio_out_o (gpio_out),
		.irq_o      (gpio_irq)
	);

	// Buttons on bits 11:8, rest tied low
	assign gpio_in = DATA_W'(btn_i) << GPIO_BTN_LSB;
	assign led_o   = gpio_out[LED_W-1:0];

	// Timer ch0, GPIO, timer ch1
	assign irq_o = {timer_irq[1], gpio_irq, timer_irq[0]};

endmodule

// ==== design/wb_bram.sv ====
/*
 * Word-addressed block RAM slave
 * Byte-lane writes, registered read data and ack
 */
`timescale 1ns/1ps

module wb_bram import soc_pkg::*; (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  logic                   stb_i,
	input  logic                   we_i,
	input  logic [BRAM_ADDR_W-1:0] adr_i,
	input  logic [DATA_W-1:0]      dat_i,
	input  logic [SEL_W-1:0]       sel_i,
	output logic [DATA_W-1:0]      dat_o,
	output logic                   ack_o
);

	// No init image, contents undefined until written
	logic [DATA_W-1:0] mem [0:(1 << BRAM_ADDR_W)-1];
	logic              access;

	// New request only while ack is low
	assign access = stb_i & ~ack_o;

	// Ack pulse
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= access;
		end
	end

	// Array and read port
	always_ff @(posedge clk_i) begin
		if (access) begin
			if (we_i) begin
				// Only selected lanes change
				for (int lane = 0; lane < SEL_W; lane++) begin
					if (sel_i[lane]) begin
						mem[adr_i][lane*8 +: 8] <= dat_i[lane*8 +: 8];
					end
				end
			end
			// Old word on a write cycle
			dat_o <= mem[adr_i];
		end
	end

endmodule

// ==== design/wb_decoder.sv ====
/*
 * Wishbone address decoder and response mux
 * Per-slave strobes, read data and ack return, default responder
 */
`timescale 1ns/1ps

module wb_decoder import soc_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic [ADDR_W-1:0] adr_i,
	input  logic              cyc_i,
	input  logic              stb_i,
	input  logic [DATA_W-1:0] bram_dat_i,
	input  logic [DATA_W-1:0] timer_dat_i,
	input  logic [DATA_W-1:0] gpio_dat_i,
	input  logic              bram_ack_i,
	input  logic              timer_ack_i,
	input  logic              gpio_ack_i,
	output logic              bram_stb_o,
	output logic              timer_stb_o,
	output logic              gpio_stb_o,
	output logic [DATA_W-1:0] dat_o,
	output logic              ack_o
);

	logic [REGION_W-1:0] region;
	slave_e              target;
	logic                req;
	logic                none_ack;

	assign region = adr_i[ADDR_W-1:REGION_LSB];
	assign req    = cyc_i & stb_i;

	// Region field to slave
	always_comb begin
		case (region)
			REGION_BRAM:  target = BRAM;
			REGION_TIMER: target = TIMER;
			REGION_GPIO:  target = GPIO;
			default:      target = NONE;
		endcase
	end

	// One strobe at most is active
	assign bram_stb_o  = req & (target == BRAM);
	assign timer_stb_o = req & (target == TIMER);
	assign gpio_stb_o  = req & (target == GPIO);

	// ------------------------------------------------------------------------
	// Default responder for unmapped space
	// ------------------------------------------------------------------------
	// Acks one cycle after the request, like a real slave
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			none_ack <= 1'b0;
		end else begin
			none_ack <= req & (target == NONE) & ~none_ack;
		end
	end

	// Return path, no extra register
	always_comb begin
		case (target)
			BRAM: begin
				dat_o = bram_dat_i;
				ack_o = bram_ack_i;
			end
			TIMER: begin
				dat_o = timer_dat_i;
				ack_o = timer_ack_i;
			end
			GPIO: begin
				dat_o = gpio_dat_i;
				ack_o = gpio_ack_i;
			end
			default: begin
				// Stray access reads zero
				dat_o = '0;
				ack_o = none_ack;
			end
		endcase
	end

endmodule

// ==== design/wb_gpio.sv ====
/*
 * GPIO slave
 * Two-flop input synchronizer, output and mask registers, level interrupt
 */
`timescale 1ns/1ps

module wb_gpio import soc_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              stb_i,
	input  logic              we_i,
	input  logic [1:0]        adr_i,
	input  logic [DATA_W-1:0] dat_i,
	input  logic [DATA_W-1:0] gpio_in_i,
	output logic [DATA_W-1:0] dat_o,
	output logic              ack_o,
	output logic [DATA_W-1:0] gpio_out_o,
	output logic              irq_o
);

	logic [DATA_W-1:0] in_meta;
	logic [DATA_W-1:0] in_sync;
	logic [DATA_W-1:0] mask_q;
	logic              access;
	gpio_reg_e         reg_sel;

	assign reg_sel = gpio_reg_e'(adr_i);
	assign access  = stb_i & ~ack_o;

	// ------------------------------------------------------------------------
	// Input synchronizer
	// ------------------------------------------------------------------------
	// Pins land in IN two cycles after they change
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			in_meta <= '0;
			in_sync <= '0;
		end else begin
			in_meta <= gpio_in_i;
			in_sync <= in_meta;
		end
	end

	// ------------------------------------------------------------------------
	// Register file
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			gpio_out_o <= '0;
			mask_q     <= '0;
			ack_o      <= 1'b0;
		end else begin
			ack_o <= access;
			// IN is read-only
			if (access && we_i) begin
				case (reg_sel)
					OUT:     gpio_out_o <= dat_i;
					MASK:    mask_q     <= dat_i;
					default: ;
				endcase
			end
		end
	end

	// Read data at the ack edge
	always_ff @(posedge clk_i) begin
		if (access) begin
			case (reg_sel)
				IN:      dat_o <= in_sync;
				OUT:     dat_o <= gpio_out_o;
				MASK:    dat_o <= mask_q;
				default: dat_o <= '0;
			endcase
		end
	end

	// High while any unmasked input is set
	assign irq_o = |(in_sync & mask_q);

endmodule

// ==== design/wb_timer.sv ====
/*
 * Two-channel timer slave
 * Per channel CTRL, COMPARE and COUNTER, one-shot or auto-reload, interrupts
 */
`timescale 1ns/1ps

module wb_timer import soc_pkg::*; (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                stb_i,
	input  logic                we_i,
	input  logic [2:0]          adr_i,
	input  logic [DATA_W-1:0]   dat_i,
	output logic [DATA_W-1:0]   dat_o,
	output logic                ack_o,
	output logic [TIMER_CH-1:0] irq_o
);

	logic [TIMER_CH-1:0] en;
	logic [TIMER_CH-1:0] ar;
	logic [TIMER_CH-1:0] irq_en;
	logic [TIMER_CH-1:0] trig;
	logic [DATA_W-1:0]   compare [TIMER_CH];
	logic [DATA_W-1:0]   counter [TIMER_CH];

	logic       access;
	logic       wr;
	logic       ch_sel;
	timer_reg_e reg_sel;

	// Bit 2 picks the channel and bits 1:0 the register
	assign ch_sel  = adr_i[2];
	assign reg_sel = timer_reg_e'(adr_i[1:0]);
	assign access  = stb_i & ~ack_o;
	assign wr      = access & we_i;

	// ------------------------------------------------------------------------
	// Counters and bus writes
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			en     <= '0;
			ar     <= '0;
			irq_en <= '0;
			trig   <= '0;
			ack_o  <= 1'b0;
			for (int ch = 0; ch < TIMER_CH; ch++) begin
				compare[ch] <= '0;
				counter[ch] <= '0;
			end
		end else begin
			ack_o <= access;
			for (int ch = 0; ch < TIMER_CH; ch++) begin
				if (en[ch]) begin
					if (counter[ch] == compare[ch]) begin
						trig[ch] <= 1'b1;
						// Restart or stop and hold
						if (ar[ch]) begin
							counter[ch] <= '0;
						end else begin
							en[ch] <= 1'b0;
						end
					end else begin
						counter[ch] <= counter[ch] + DATA_W'(1);
					end
				end
			end
			// Bus write wins over the count logic
			if (wr) begin
				case (reg_sel)
					CTRL: begin
						en[ch_sel]     <= dat_i[CTRL_EN];
						ar[ch_sel]     <= dat_i[CTRL_AR];
						irq_en[ch_sel] <= dat_i[CTRL_IRQ_EN];
						// Write one to clear
						if (dat_i[CTRL_TRIG]) begin
							trig[ch_sel] <= 1'b0;
						end
					end
					COMPARE: compare[ch_sel] <= dat_i;
					COUNTER: counter[ch_sel] <= dat_i;
					default: ;
				endcase
			end
		end
	end

	// Read data registered at the ack edge
	always_ff @(posedge clk_i) begin
		if (access) begin
			case (reg_sel)
				CTRL: begin
					dat_o <= {{(DATA_W-4){1'b0}}, trig[ch_sel], irq_en[ch_sel],
						ar[ch_sel], en[ch_sel]};
				end
				COMPARE: dat_o <= compare[ch_sel];
				COUNTER: dat_o <= counter[ch_sel];
				default: dat_o <= '0;
			endcase
		end
	end

	// Level interrupt per channel
	assign irq_o = trig & irq_en;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator.
# Exit status is nonzero when the build, the run or any check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_top -f sim.f -o tb_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi

if ! grep -q "Verification passed" "$LOG"; then
	echo "No pass message in $LOG"
	exit 1
fi

exit 0

// ==== sim.f ====
design/soc_pkg.sv
design/wb_decoder.sv
design/wb_bram.sv
design/wb_timer.sv
design/wb_gpio.sv
design/soc_top.sv
tests/soc_chk.sv
tests/soc_monitor.sv
tests/tb_top.sv

// ==== tests/soc_chk.sv ====
/*
 * Bus and interrupt protocol assertions, bound to the subsystem top
 */
`timescale 1ns/1ps

module soc_chk import soc_pkg::*; (
	input logic             clk_i,
	input logic             rst_n_i,
	input logic             wb_cyc_i,
	input logic             wb_stb_i,
	input logic             wb_ack_o,
	input logic [IRQ_W-1:0] irq_o,
	input logic [LED_W-1:0] led_o
);

	// Ack only answers a request from the previous cycle
	ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i))
		else $error("ack without cyc and stb");

	// Single-cycle ack pulse
	ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_o |=> !wb_ack_o)
		else $error("ack high two cycles running");

	// Outputs quiet right after reset
	quiet_after_reset: assert property (@(posedge clk_i)
		$rose(rst_n_i) |-> (irq_o == '0) && (led_o == '0))
		else $error("irq_o or led_o not zero after reset");

endmodule

bind soc_top soc_chk u_chk (.*);

// ==== tests/soc_monitor.sv ====
/*
 * Port monitor with reference model
 * Block RAM lanes, GPIO OUT and MASK, button pipeline, read and pin checks
 */
`timescale 1ns/1ps

module soc_monitor import soc_pkg::*; (
	input logic              clk_i,
	input logic              rst_n_i,
	input logic [ADDR_W-1:0] adr_i,
	input logic [DATA_W-1:0] wdat_i,
	input logic [SEL_W-1:0]  sel_i,
	input logic              we_i,
	input logic              cyc_i,
	input logic              stb_i,
	input logic [DATA_W-1:0] rdat_i,
	input logic              ack_i,
	input logic [BTN_W-1:0]  btn_i,
	input logic [LED_W-1:0]  led_i,
	input logic [IRQ_W-1:0]  irq_i
);

	// Model state
	logic [DATA_W-1:0] bram_m [int];
	logic [SEL_W-1:0]  bram_v [int];
	logic [DATA_W-1:0] out_m;
	logic [DATA_W-1:0] mask_m;
	logic [BTN_W-1:0]  btn_d1;
	logic [BTN_W-1:0]  btn_d2;

	// Pending read expectation
	logic [DATA_W-1:0] exp_dat;
	logic [DATA_W-1:0] exp_mask;
	logic              exp_valid;

	logic [REGION_W-1:0] region;
	int                  word;
	int                  test_errs = 0;
	int                  pass_cnt = 0;
	int                  fail_cnt = 0;

	task automatic report(input string msg);
		test_errs++;
		$display("FAIL @%0t: %s", $time, msg);
	endtask

	task automatic check_eq(input string what, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			report($sformatf("%s got %h expected %h", what, got, exp));
		end
	endtask

	task automatic check_true(input string what, input logic cond);
		if (cond !== 1'b1) begin
			report(what);
		end
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0) begin
			pass_cnt++;
			$display("Test %s: PASS", name);
		end else begin
			fail_cnt++;
			$display("Test %s: FAIL (%0d errors)", name, test_errs);
		end
		test_errs = 0;
	endtask

	// Buttons through two flops, as the GPIO input path
	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			btn_d1 <= '0;
			btn_d2 <= '0;
		end else begin
			btn_d1 <= btn_i;
			btn_d2 <= btn_d1;
		end
	end

	// ------------------------------------------------------------------------
	// Bus side: writes land at the access edge, reads compared at ack
	// ------------------------------------------------------------------------
	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			out_m     = '0;
			mask_m    = '0;
			exp_valid = 1'b0;
		end else begin
			if (ack_i && exp_valid) begin
				if ((rdat_i & exp_mask) !== (exp_dat & exp_mask)) begin
					report($sformatf("read %h got %h expected %h (lanes %h)",
						adr_i, rdat_i, exp_dat, exp_mask));
				end
			end
			if (ack_i) begin
				exp_valid = 1'b0;
			end
			if (cyc_i && stb_i && !ack_i) begin
				region    = adr_i[ADDR_W-1:REGION_LSB];
				exp_mask  = '1;
				exp_valid = 1'b0;
				if (region == REGION_BRAM) begin
					word = int'(adr_i[BRAM_ADDR_W+1:2]);
					if (!bram_m.exists(word)) begin
						bram_m[word] = '0;
						bram_v[word] = '0;
					end
					if (we_i) begin
						// Replace only the selected bytes
						for (int lane = 0; lane < SEL_W; lane++) begin
							if (sel_i[lane]) begin
								bram_m[word][lane*8 +: 8] = wdat_i[lane*8 +: 8];
								bram_v[word][lane] = 1'b1;
							end
						end
					end else begin
						for (int lane = 0; lane < SEL_W; lane++) begin
							exp_mask[lane*8 +: 8] = {8{bram_v[word][lane]}};
						end
						exp_dat   = bram_m[word];
						exp_valid = 1'b1;
					end
				end else if (region == REGION_GPIO) begin
					if (we_i && adr_i[3:2] == 2'd1) begin
						out_m = wdat_i;
					end else if (we_i && adr_i[3:2] == 2'd2) begin
						mask_m = wdat_i;
					end else if (!we_i && adr_i[3:2] != 2'd3) begin
						case (adr_i[3:2])
							2'd0:    exp_dat = DATA_W'(btn_d2) << GPIO_BTN_LSB;
							2'd1:    exp_dat = out_m;
							default: exp_dat = mask_m;
						endcase
						exp_valid = 1'b1;
					end
				end else if (region != REGION_TIMER && !we_i) begin
					// Unmapped space reads zero
					exp_dat   = '0;
					exp_valid = 1'b1;
				end
			end
		end
	end

	// Pin side, checked mid-cycle
	always @(negedge clk_i) begin
		if (rst_n_i) begin
			if (led_i !== out_m[LED_W-1:0]) begin
				report($sformatf("led_o %h expected %h", led_i, out_m[LED_W-1:0]));
			end
			if (irq_i[1] !== |((DATA_W'(btn_d2) << GPIO_BTN_LSB) & mask_m)) begin
				report($sformatf("GPIO irq %b with buttons %h", irq_i[1], btn_d2));
			end
		end
	end

endmodule

// ==== tests/tb_top.sv ====
/*
 * Testbench top with clock, reset, LFSR and bus-master tasks
 * Stimulus sequence, watchdog and run summary
 */
`timescale 1ns/1ps

module tb_top import soc_pkg::*; ();

	localparam int BRAM_WRITES = 200;
	// Bus transactions over the whole run and extra cycles for timer polling
	localparam int TXN_COUNT   = 2 * BRAM_WRITES + 120;
	localparam int TIMER_WAIT  = 4 * 512;
	localparam int WATCHDOG    = TXN_COUNT * 20 + TIMER_WAIT;

	logic              clk;
	logic              rst_n;
	logic [ADDR_W-1:0] wb_adr;
	logic [DATA_W-1:0] wb_wdat;
	logic [SEL_W-1:0]  wb_sel;
	logic              wb_we;
	logic              wb_cyc;
	logic              wb_stb;
	logic [BTN_W-1:0]  btn;
	logic [DATA_W-1:0] wb_rdat;
	logic              wb_ack;
	logic [LED_W-1:0]  led;
	logic [IRQ_W-1:0]  irq;

	logic [31:0]       lfsr_state;
	logic [DATA_W-1:0] rd;
	logic [DATA_W-1:0] val;
	logic [DATA_W-1:0] cmp;
	logic [DATA_W-1:0] saved;
	int                words [$];

	soc_top u_soc_top (
		.clk_i    (clk),
		.rst_n_i  (rst_n),
		.wb_adr_i (wb_adr),
		.wb_dat_i (wb_wdat),
		.wb_sel_i (wb_sel),
		.wb_we_i  (wb_we),
		.wb_cyc_i (wb_cyc),
		.wb_stb_i (wb_stb),
		.btn_i    (btn),
		.wb_dat_o (wb_rdat),
		.wb_ack_o (wb_ack),
		.led_o    (led),
		.irq_o    (irq)
	);

	soc_monitor u_mon (
		.clk_i   (clk),
		.rst_n_i (rst_n),
		.adr_i   (wb_adr),
		.wdat_i  (wb_wdat),
		.sel_i   (wb_sel),
		.we_i    (wb_we),
		.cyc_i   (wb_cyc),
		.stb_i   (wb_stb),
		.rdat_i  (wb_rdat),
		.ack_i   (wb_ack),
		.btn_i   (btn),
		.led_i   (led),
		.irq_i   (irq)
	);

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [ADDR_W-1:0] timer_adr(input int ch, input timer_reg_e r);
		return {REGION_TIMER, 17'(ch * 16 + int'(r) * 4)};
	endfunction

	function automatic logic [ADDR_W-1:0] gpio_adr(input gpio_reg_e r);
		return {REGION_GPIO, 17'(int'(r) * 4)};
	endfunction

	// ------------------------------------------------------------------------
	// Classic-cycle master tasks start and return on a falling edge
	// ------------------------------------------------------------------------
	task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
		input logic [SEL_W-1:0] sel);
		wb_adr  = adr;
		wb_wdat = dat;
		wb_sel  = sel;
		wb_we   = 1'b1;
		wb_cyc  = 1'b1;
		wb_stb  = 1'b1;
		@(negedge clk);
		while (!wb_ack) @(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clk);
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] dat);
		wb_adr = adr;
		wb_sel = '1;
		wb_we  = 1'b0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		@(negedge clk);
		while (!wb_ack) @(negedge clk);
		dat    = wb_rdat;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(negedge clk);
	endtask

	// Start a channel and poll until TRIG
	task automatic timer_run(input int ch, input logic [3:0] ctrl, output logic [31:0] c);
		c = 32'(rand_bits(8) % 255 + 1);
		bus_write(timer_adr(ch, COUNTER), '0, '1);
		bus_write(timer_adr(ch, COMPARE), c, '1);
		bus_write(timer_adr(ch, CTRL), 32'(ctrl), '1);
		do begin
			bus_read(timer_adr(ch, CTRL), rd);
		end while (!rd[CTRL_TRIG]);
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG) @(posedge clk);
		$display("Run timed out after %0d cycles", WATCHDOG);
		$display("Verification failed");
		$finish;
	end

	initial begin
		lfsr_state = 32'd10;
		rst_n   = 1'b0;
		wb_adr  = '0;
		wb_wdat = '0;
		wb_sel  = '0;
		wb_we   = 1'b0;
		wb_cyc  = 1'b0;
		wb_stb  = 1'b0;
		btn     = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// Block RAM byte lanes checked by the monitor
		for (int i = 0; i < BRAM_WRITES; i++) begin
			words.push_back(int'(rand_bits(BRAM_ADDR_W)));
			bus_write({REGION_BRAM, 3'b0, words[i][BRAM_ADDR_W-1:0], 2'b00},
				rand_bits(32), SEL_W'(rand_bits(4)));
		end
		foreach (words[i]) begin
			bus_read({REGION_BRAM, 3'b0, words[i][BRAM_ADDR_W-1:0], 2'b00}, rd);
		end
		u_mon.end_test("bram_byte_lanes");

		// OUT to LEDs with OUT and MASK readback
		val = rand_bits(32);
		bus_write(gpio_adr(OUT), val, '1);
		bus_write(gpio_adr(MASK), rand_bits(32), '1);
		bus_read(gpio_adr(OUT), rd);
		bus_read(gpio_adr(MASK), rd);
		u_mon.check_eq("led_o", 32'(led), 32'(val[LED_W-1:0]));
		u_mon.end_test("gpio_out_mask");

		// Buttons through the synchronizer and the masked interrupt
		for (int i = 0; i < 12; i++) begin
			bus_write(gpio_adr(MASK), DATA_W'(rand_bits(4)) << GPIO_BTN_LSB, '1);
			btn = BTN_W'(rand_bits(4));
			repeat (3) @(negedge clk);
			bus_read(gpio_adr(IN), rd);
		end
		u_mon.end_test("gpio_buttons");

		// One-shot per channel on irq bit 0 or 2
		for (int ch = 0; ch < TIMER_CH; ch++) begin
			timer_run(ch, 4'b0101, cmp);
			u_mon.check_eq("one-shot EN", 32'(rd[CTRL_EN]), 32'd0);
			bus_read(timer_adr(ch, COUNTER), rd);
			u_mon.check_eq("one-shot COUNTER", rd, cmp);
			u_mon.check_true("timer irq not set", irq[ch * 2]);
			bus_write(timer_adr(ch, CTRL), 32'h8, '1);
			bus_read(timer_adr(ch, CTRL), rd);
			u_mon.check_eq("TRIG after clear", 32'(rd[CTRL_TRIG]), 32'd0);
			u_mon.check_true("timer irq not cleared", !irq[ch * 2]);
		end
		u_mon.end_test("timer_one_shot");

		// Auto-reload keeps running
		for (int ch = 0; ch < TIMER_CH; ch++) begin
			timer_run(ch, 4'b0011, cmp);
			u_mon.check_eq("reload EN", 32'(rd[CTRL_EN]), 32'd1);
			bus_read(timer_adr(ch, COUNTER), rd);
			u_mon.check_true($sformatf("reload COUNTER %0d above %0d", rd, cmp), rd <= cmp);
			bus_write(timer_adr(ch, CTRL), 32'h8, '1);
		end
		u_mon.end_test("timer_auto_reload");

		// Unmapped region aliasing a written RAM word
		val = rand_bits(BRAM_ADDR_W);
		// Low bits also alias timer ch0 COMPARE and GPIO OUT
		val[2:0] = 3'b001;
		bus_write({REGION_BRAM, 3'b0, val[BRAM_ADDR_W-1:0], 2'b00}, rand_bits(32), '1);
		bus_read(timer_adr(0, COMPARE), saved);
		do begin
			cmp = rand_bits(REGION_W);
		end while (cmp[REGION_W-1:0] inside {REGION_BRAM, REGION_TIMER, REGION_GPIO});
		bus_write({cmp[REGION_W-1:0], 3'b0, val[BRAM_ADDR_W-1:0], 2'b00}, rand_bits(32), '1);
		bus_read({cmp[REGION_W-1:0], 3'b0, val[BRAM_ADDR_W-1:0], 2'b00}, rd);
		u_mon.check_eq("unmapped read", rd, '0);
		bus_read({REGION_BRAM, 3'b0, val[BRAM_ADDR_W-1:0], 2'b00}, rd);
		bus_read(gpio_adr(OUT), rd);
		bus_read(gpio_adr(MASK), rd);
		bus_read(timer_adr(0, COMPARE), rd);
		u_mon.check_eq("timer COMPARE after stray write", rd, saved);
		u_mon.end_test("unmapped_access");

		$display("Tests: %0d passed, %0d failed", u_mon.pass_cnt, u_mon.fail_cnt);
		if (u_mon.fail_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
